// ==== source/rvc_cfg.svh ====
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// instruction widths
`define RVC_INSTR_W 32
`define RVC_CINSTR_W 16

// register file index width
`define RVC_REG_W 5

// implied registers of the compressed forms
`define RVC_SP_REG 2
`define RVC_RA_REG 1

`endif

// ==== source/rvc_isa_pkg.sv ====
`include "rvc_cfg.svh"

package rvc_isa_pkg;

	typedef logic [`RVC_INSTR_W-1:0] instr_t;
	typedef logic [`RVC_CINSTR_W-1:0] cinstr_t;
	typedef logic [`RVC_REG_W-1:0] reg_idx_t;

	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// I, S and B immediates
	typedef logic [11:0] imm12_t;
	// U and J immediates
	typedef logic [19:0] imm20_t;

	// major opcodes, bits 6:2 of the base word
	typedef enum logic [4:0] {
		opc_load = 5'b00000,
		opc_op_imm = 5'b00100,
		opc_op_imm_32 = 5'b00110,
		opc_store = 5'b01000,
		opc_op = 5'b01100,
		opc_lui = 5'b01101,
		opc_op_32 = 5'b01110,
		opc_branch = 5'b11000,
		opc_jalr = 5'b11001,
		opc_jal = 5'b11011,
		opc_system = 5'b11100
	} rvc_opcode_e;

endpackage

// ==== source/rvc_expand_pkg.sv ====
package rvc_expand_pkg;

	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} rvc_format_e;

	// decoded operands of one compressed instruction
	// imm holds offset[12:1] for B and offset[20:1] for J
	typedef struct packed {
		logic illegal;
		rvc_format_e format;
		rvc_isa_pkg::rvc_opcode_e opcode;
		rvc_isa_pkg::reg_idx_t rd;
		rvc_isa_pkg::funct3_t funct3;
		rvc_isa_pkg::reg_idx_t rs1;
		rvc_isa_pkg::reg_idx_t rs2;
		rvc_isa_pkg::funct7_t funct7;
		rvc_isa_pkg::imm20_t imm;
	} rvc_fields_t;

	typedef struct packed {
		rvc_isa_pkg::instr_t instr;
		logic compressed;
		logic illegal;
	} rvc_result_t;

endpackage

// ==== source/rvc_quadrant0.sv ====
`timescale 1ns/1ns
`include "rvc_cfg.svh"

module rvc_quadrant0 #(
	parameter bit rv64_p = 1'b1
) (
	input rvc_isa_pkg::cinstr_t half_i,
	output rvc_expand_pkg::rvc_fields_t fields_o
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	reg_idx_t reg_lo;
	reg_idx_t reg_hi;
	imm12_t word_off;
	imm12_t dword_off;

	// x8..x15
	assign reg_lo = {2'b01, half_i[4:2]};
	assign reg_hi = {2'b01, half_i[9:7]};
	assign word_off = 12'({half_i[5], half_i[12:10], half_i[6], 2'b00});
	assign dword_off = 12'({half_i[6:5], half_i[12:10], 3'b000});

	always_comb begin
		fields_o = '0;
		fields_o.rs1 = reg_hi;
		case (half_i[15:13])
			3'b000: begin
				// addi4spn
				fields_o.illegal = (half_i == '0);
				fields_o.format = fmt_i;
				fields_o.opcode = opc_op_imm;
				fields_o.rd = reg_lo;
				fields_o.rs1 = reg_idx_t'(`RVC_SP_REG);
				fields_o.imm[11:0] = 12'({half_i[10:7], half_i[12:11], half_i[5], half_i[6], 2'b00});
			end
			3'b010, 3'b011: begin
				// lw, ld
				fields_o.illegal = half_i[13] && !rv64_p;
				fields_o.format = fmt_i;
				fields_o.opcode = opc_load;
				fields_o.rd = reg_lo;
				fields_o.funct3 = {2'b01, half_i[13]};
				fields_o.imm[11:0] = half_i[13] ? dword_off : word_off;
			end
			3'b110, 3'b111: begin
				// sw, sd
				fields_o.illegal = half_i[13] && !rv64_p;
				fields_o.format = fmt_s;
				fields_o.opcode = opc_store;
				fields_o.rs2 = reg_lo;
				fields_o.funct3 = {2'b01, half_i[13]};
				fields_o.imm[11:0] = half_i[13] ? dword_off : word_off;
			end
			default: fields_o.illegal = 1'b1;
		endcase
	end

endmodule

// ==== source/rvc_quadrant1.sv ====
`timescale 1ns/1ns
`include "rvc_cfg.svh"

module rvc_quadrant1 #(
	parameter bit rv64_p = 1'b1
) (
	input rvc_isa_pkg::cinstr_t half_i,
	output rvc_expand_pkg::rvc_fields_t fields_o
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	reg_idx_t rd_full;
	reg_idx_t rd_prime;
	reg_idx_t rs2_prime;
	imm12_t imm6_sx;
	imm20_t jump_off;
	imm12_t branch_off;

	assign rd_full = half_i[11:7];
	assign rd_prime = {2'b01, half_i[9:7]};
	assign rs2_prime = {2'b01, half_i[4:2]};
	assign imm6_sx = 12'(signed'({half_i[12], half_i[6:2]}));

	// offset[11:1] and offset[8:1], bits scattered in the halfword
	assign jump_off = 20'(signed'({half_i[12], half_i[8], half_i[10:9], half_i[6],
		half_i[7], half_i[2], half_i[11], half_i[5:3]}));
	assign branch_off = 12'(signed'({half_i[12], half_i[6:5], half_i[2],
		half_i[11:10], half_i[4:3]}));

	always_comb begin
		fields_o = '0;
		case (half_i[15:13])
			3'b000, 3'b010: begin
				// addi, li
				fields_o.format = fmt_i;
				fields_o.opcode = opc_op_imm;
				fields_o.rd = rd_full;
				fields_o.rs1 = half_i[14] ? '0 : rd_full;
				fields_o.imm[11:0] = imm6_sx;
			end
			3'b001: begin
				if (rv64_p) begin
					// addiw
					fields_o.format = fmt_i;
					fields_o.opcode = opc_op_imm_32;
					fields_o.rd = rd_full;
					fields_o.rs1 = rd_full;
					fields_o.imm[11:0] = imm6_sx;
				end else begin
					// jal
					fields_o.format = fmt_j;
					fields_o.opcode = opc_jal;
					fields_o.rd = reg_idx_t'(`RVC_RA_REG);
					fields_o.imm = jump_off;
				end
			end
			3'b011: begin
				if (rd_full == reg_idx_t'(`RVC_SP_REG)) begin
					// addi16sp
					fields_o.format = fmt_i;
					fields_o.opcode = opc_op_imm;
					fields_o.rd = rd_full;
					fields_o.rs1 = rd_full;
					fields_o.imm[11:0] = 12'(signed'({half_i[12], half_i[4:3], half_i[5],
						half_i[2], half_i[6], 4'b0000}));
				end else begin
					// lui
					fields_o.format = fmt_u;
					fields_o.opcode = opc_lui;
					fields_o.rd = rd_full;
					fields_o.imm = 20'(signed'({half_i[12], half_i[6:2]}));
				end
			end
			3'b100: begin
				fields_o.rd = rd_prime;
				fields_o.rs1 = rd_prime;
				case (half_i[11:10])
					2'b00, 2'b01: begin
						// srli, srai
						fields_o.format = fmt_i;
						fields_o.opcode = opc_op_imm;
						fields_o.funct3 = 3'b101;
						fields_o.imm[11:0] = {1'b0, half_i[10], 4'b0000, half_i[12], half_i[6:2]};
					end
					2'b10: begin
						// andi
						fields_o.format = fmt_i;
						fields_o.opcode = opc_op_imm;
						fields_o.funct3 = 3'b111;
						fields_o.imm[11:0] = imm6_sx;
					end
					default: begin
						fields_o.format = fmt_r;
						fields_o.rs2 = rs2_prime;
						if (!half_i[12]) begin
							// sub, xor, or, and
							fields_o.opcode = opc_op;
							fields_o.funct3 = {|half_i[6:5], half_i[6], &half_i[6:5]};
							fields_o.funct7 = {1'b0, ~|half_i[6:5], 5'b00000};
						end else if (rv64_p && !half_i[6]) begin
							// subw, addw
							fields_o.opcode = opc_op_32;
							fields_o.funct7 = {1'b0, ~half_i[5], 5'b00000};
						end else begin
							fields_o.illegal = 1'b1;
						end
					end
				endcase
			end
			3'b101: begin
				// j
				fields_o.format = fmt_j;
				fields_o.opcode = opc_jal;
				fields_o.imm = jump_off;
			end
			default: begin
				// beqz, bnez
				fields_o.format = fmt_b;
				fields_o.opcode = opc_branch;
				fields_o.funct3 = {2'b00, half_i[13]};
				fields_o.rs1 = rd_prime;
				fields_o.imm[11:0] = branch_off;
			end
		endcase
	end

endmodule

// ==== source/rvc_quadrant2.sv ====
`timescale 1ns/1ns
`include "rvc_cfg.svh"

module rvc_quadrant2 #(
	parameter bit rv64_p = 1'b1
) (
	input rvc_isa_pkg::cinstr_t half_i,
	output rvc_expand_pkg::rvc_fields_t fields_o
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	reg_idx_t rd_full;
	reg_idx_t rs2_full;

	assign rd_full = half_i[11:7];
	assign rs2_full = half_i[6:2];

	always_comb begin
		fields_o = '0;
		case (half_i[15:13])
			3'b000: begin
				// slli
				fields_o.format = fmt_i;
				fields_o.opcode = opc_op_imm;
				fields_o.funct3 = 3'b001;
				fields_o.rd = rd_full;
				fields_o.rs1 = rd_full;
				fields_o.imm[11:0] = {6'b000000, half_i[12], half_i[6:2]};
			end
			3'b010, 3'b011: begin
				// lwsp, ldsp
				fields_o.illegal = half_i[13] && !rv64_p;
				fields_o.format = fmt_i;
				fields_o.opcode = opc_load;
				fields_o.funct3 = {2'b01, half_i[13]};
				fields_o.rd = rd_full;
				fields_o.rs1 = reg_idx_t'(`RVC_SP_REG);
				fields_o.imm[11:0] = half_i[13]
					? 12'({half_i[4:2], half_i[12], half_i[6:5], 3'b000})
					: 12'({half_i[3:2], half_i[12], half_i[6:4], 2'b00});
			end
			3'b100: begin
				if (rd_full == '0) begin
					// only ebreak lives at rs1 zero
					fields_o.illegal = !(half_i[12] && rs2_full == '0);
					fields_o.format = fmt_r;
					fields_o.opcode = opc_system;
					fields_o.rs2 = 5'd1;
				end else if (rs2_full == '0) begin
					// jr, jalr
					fields_o.format = fmt_i;
					fields_o.opcode = opc_jalr;
					fields_o.rd = half_i[12] ? reg_idx_t'(`RVC_RA_REG) : '0;
					fields_o.rs1 = rd_full;
				end else begin
					// mv, add
					fields_o.format = fmt_r;
					fields_o.opcode = opc_op;
					fields_o.rd = rd_full;
					fields_o.rs1 = half_i[12] ? rd_full : '0;
					fields_o.rs2 = rs2_full;
				end
			end
			3'b110, 3'b111: begin
				// swsp, sdsp
				fields_o.illegal = half_i[13] && !rv64_p;
				fields_o.format = fmt_s;
				fields_o.opcode = opc_store;
				fields_o.funct3 = {2'b01, half_i[13]};
				fields_o.rs1 = reg_idx_t'(`RVC_SP_REG);
				fields_o.rs2 = rs2_full;
				fields_o.imm[11:0] = half_i[13]
					? 12'({half_i[9:7], half_i[12:10], 3'b000})
					: 12'({half_i[8:7], half_i[12:9], 2'b00});
			end
			default: fields_o.illegal = 1'b1;
		endcase
	end

endmodule

// ==== source/rvc_format_pack.sv ====
`timescale 1ns/1ns

module rvc_format_pack (
	input rvc_isa_pkg::instr_t word_i,
	input rvc_expand_pkg::rvc_fields_t q0_i,
	input rvc_expand_pkg::rvc_fields_t q1_i,
	input rvc_expand_pkg::rvc_fields_t q2_i,
	output rvc_expand_pkg::rvc_result_t result_o
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	rvc_fields_t sel;
	instr_t pack_word;

	// pattern 11 falls through to q2 and is ignored below
	always_comb begin
		case (word_i[1:0])
			2'b00: sel = q0_i;
			2'b01: sel = q1_i;
			default: sel = q2_i;
		endcase
	end

	always_comb begin
		case (sel.format)
			fmt_r: pack_word = {sel.funct7, sel.rs2, sel.rs1, sel.funct3, sel.rd,
				sel.opcode, 2'b11};
			fmt_i: pack_word = {sel.imm[11:0], sel.rs1, sel.funct3, sel.rd,
				sel.opcode, 2'b11};
			fmt_s: pack_word = {sel.imm[11:5], sel.rs2, sel.rs1, sel.funct3,
				sel.imm[4:0], sel.opcode, 2'b11};
			fmt_b: pack_word = {sel.imm[11], sel.imm[9:4], sel.rs2, sel.rs1, sel.funct3,
				sel.imm[3:0], sel.imm[10], sel.opcode, 2'b11};
			fmt_u: pack_word = {sel.imm, sel.rd, sel.opcode, 2'b11};
			// J layout
			default: pack_word = {sel.imm[19], sel.imm[9:0], sel.imm[10], sel.imm[18:11],
				sel.rd, sel.opcode, 2'b11};
		endcase
	end

	always_comb begin
		if (word_i[1:0] == 2'b11) begin
			result_o.instr = word_i;
			result_o.compressed = 1'b0;
			result_o.illegal = 1'b0;
		end else begin
			result_o.instr = pack_word;
			result_o.compressed = 1'b1;
			result_o.illegal = sel.illegal;
		end
	end

	// an all-zero halfword never expands
	assert final (word_i[15:0] != '0 || result_o.illegal);

endmodule

// ==== source/rvc_expander.sv ====
`timescale 1ns/1ns
`include "rvc_cfg.svh"

module rvc_expander #(
	parameter bit rv64_p = 1'b1
) (
	input logic clk_i,
	input logic reset_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input rvc_isa_pkg::instr_t in_word_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output rvc_expand_pkg::rvc_result_t out_result_o
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	cinstr_t half;
	rvc_fields_t q0_fields;
	rvc_fields_t q1_fields;
	rvc_fields_t q2_fields;
	rvc_result_t next_result;

	assign half = in_word_i[`RVC_CINSTR_W-1:0];

	rvc_quadrant0 #(.rv64_p(rv64_p)) u_quadrant0 (
		.half_i(half),
		.fields_o(q0_fields)
	);

	rvc_quadrant1 #(.rv64_p(rv64_p)) u_quadrant1 (
		.half_i(half),
		.fields_o(q1_fields)
	);

	rvc_quadrant2 #(.rv64_p(rv64_p)) u_quadrant2 (
		.half_i(half),
		.fields_o(q2_fields)
	);

	rvc_format_pack u_format_pack (
		.word_i(in_word_i),
		.q0_i(q0_fields),
		.q1_i(q1_fields),
		.q2_i(q2_fields),
		.result_o(next_result)
	);

	// stage can refill in the cycle it drains
	assign in_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			out_result_o <= next_result;
		end
	end

	// held result under back-pressure
	assert property (@(posedge clk_i) disable iff (reset_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o));

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);
	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (4) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== tb/tb_rvc_model.svh ====
`ifndef TB_RVC_MODEL_SVH
`define TB_RVC_MODEL_SVH

`include "rvc_cfg.svh"

function automatic instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic instr_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

// branch and jump offsets keep their bit 0
function automatic instr_t b_type(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op};
endfunction

function automatic instr_t u_type(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic instr_t j_type(input logic [20:0] off, input logic [4:0] rd,
	input logic [6:0] op);
	return {off[20], off[10:1], off[11], off[19:12], rd, op};
endfunction

function automatic rvc_result_t rvc_expand_ref(input instr_t word, input bit rv64);
	rvc_result_t res;
	logic [15:0] c;
	logic [4:0] rd;
	logic [4:0] rs2;
	logic [4:0] rdp;
	logic [4:0] rs2p;
	logic [4:0] sp;
	logic [4:0] ra;
	logic [2:0] alu_f3;
	logic [11:0] imm6;
	logic [11:0] woff;
	logic [11:0] doff;
	logic [11:0] shamt;
	logic [20:0] joff;
	logic [12:0] boff;
	c = word[15:0];
	rd = c[11:7];
	rs2 = c[6:2];
	rdp = {2'b01, c[9:7]};
	rs2p = {2'b01, c[4:2]};
	sp = `RVC_SP_REG;
	ra = `RVC_RA_REG;
	alu_f3 = (c[6:5] == 2'b00) ? 3'b000 : (c[6:5] == 2'b01) ? 3'b100 :
		(c[6:5] == 2'b10) ? 3'b110 : 3'b111;
	imm6 = {{7{c[12]}}, c[6:2]};
	woff = {5'b0, c[5], c[12:10], c[6], 2'b00};
	doff = {4'b0, c[6:5], c[12:10], 3'b000};
	shamt = {6'b0, c[12], c[6:2]};
	joff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	boff = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
	res.instr = word;
	res.compressed = (word[1:0] != 2'b11);
	res.illegal = 1'b0;
	if (!res.compressed)
		return res;
	case ({c[1:0], c[15:13]})
		5'b00_000: begin
			// addi4spn
			res.illegal = (c == 16'h0000);
			res.instr = i_type({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00}, sp, 3'b000,
				rs2p, 7'h13);
		end
		5'b00_010: res.instr = i_type(woff, rdp, 3'b010, rs2p, 7'h03);
		5'b00_011: begin
			res.illegal = !rv64;
			res.instr = i_type(doff, rdp, 3'b011, rs2p, 7'h03);
		end
		5'b00_110: res.instr = s_type(woff, rs2p, rdp, 3'b010, 7'h23);
		5'b00_111: begin
			res.illegal = !rv64;
			res.instr = s_type(doff, rs2p, rdp, 3'b011, 7'h23);
		end
		5'b01_000: res.instr = i_type(imm6, rd, 3'b000, rd, 7'h13);
		5'b01_001: begin
			// addiw on RV64, jal on RV32
			res.instr = rv64 ? i_type(imm6, rd, 3'b000, rd, 7'h1b) : j_type(joff, ra, 7'h6f);
		end
		5'b01_010: res.instr = i_type(imm6, 5'd0, 3'b000, rd, 7'h13);
		5'b01_011: begin
			if (rd == sp) begin
				res.instr = i_type({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000}, rd,
					3'b000, rd, 7'h13);
			end else begin
				res.instr = u_type({{14{c[12]}}, c[12], c[6:2]}, rd, 7'h37);
			end
		end
		5'b01_100: begin
			case (c[11:10])
				2'b00: res.instr = i_type(shamt, rdp, 3'b101, rdp, 7'h13);
				2'b01: res.instr = i_type(shamt | 12'h400, rdp, 3'b101, rdp, 7'h13);
				2'b10: res.instr = i_type(imm6, rdp, 3'b111, rdp, 7'h13);
				default: begin
					if (!c[12]) begin
						res.instr = r_type((c[6:5] == 2'b00) ? 7'h20 : 7'h00, rs2p, rdp,
							alu_f3, rdp, 7'h33);
					end else begin
						// only subw and addw left here
						res.illegal = !rv64 || c[6];
						res.instr = r_type(c[5] ? 7'h00 : 7'h20, rs2p, rdp, 3'b000, rdp, 7'h3b);
					end
				end
			endcase
		end
		5'b01_101: res.instr = j_type(joff, 5'd0, 7'h6f);
		5'b01_110, 5'b01_111: res.instr = b_type(boff, 5'd0, rdp, {2'b00, c[13]}, 7'h63);
		5'b10_000: res.instr = i_type(shamt, rd, 3'b001, rd, 7'h13);
		5'b10_010: begin
			res.instr = i_type({4'b0, c[3:2], c[12], c[6:4], 2'b00}, sp, 3'b010, rd, 7'h03);
		end
		5'b10_011: begin
			res.illegal = !rv64;
			res.instr = i_type({3'b0, c[4:2], c[12], c[6:5], 3'b000}, sp, 3'b011, rd, 7'h03);
		end
		5'b10_100: begin
			if (rd == 5'd0) begin
				// ebreak is the only form without rd
				res.illegal = !(c[12] && rs2 == 5'd0);
				res.instr = 32'h0010_0073;
			end else if (rs2 == 5'd0) begin
				res.instr = i_type(12'd0, rd, 3'b000, c[12] ? ra : 5'd0, 7'h67);
			end else begin
				res.instr = r_type(7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33);
			end
		end
		5'b10_110: res.instr = s_type({4'b0, c[8:7], c[12:9], 2'b00}, rs2, sp, 3'b010, 7'h23);
		5'b10_111: begin
			res.illegal = !rv64;
			res.instr = s_type({3'b0, c[9:7], c[12:10], 3'b000}, rs2, sp, 3'b011, 7'h23);
		end
		// floating point and reserved slots
		default: res.illegal = 1'b1;
	endcase
	return res;
endfunction

`endif

// ==== tb/tb_rvc_expander.sv ====
`timescale 1ns/1ns

module tb_rvc_expander #(
	parameter bit rv64 = 1'b1
);
	import rvc_isa_pkg::*;
	import rvc_expand_pkg::*;

	`include "tb_rvc_model.svh"

	localparam int n_directed = 57;
	localparam int n_random = 2000;
	localparam int n_words = n_directed + n_random;
	localparam int cycle_limit = 4 * n_words + 100;

	// halfword in 15:0, bit 16 illegal on RV64, bit 17 illegal on RV32
	localparam logic [17:0] directed [n_directed] = '{
		18'h00040, 18'h01ffc, 18'h04bd8, 18'h0c3fc, 18'h00001, 18'h01ffd, 18'h02ffd, 18'h03081,
		18'h05ffd, 18'h0717d, 18'h06ffd, 18'h0807d, 18'h0907d, 18'h0847d, 18'h0947d, 18'h088fd,
		18'h098fd, 18'h08c1d, 18'h08c3d, 18'h08c5d, 18'h08c7d, 18'h0a001, 18'h0bffd, 18'h0c001,
		18'h0dffd, 18'h0e001, 18'h0fffd, 18'h01ffe, 18'h05ffe, 18'h08082, 18'h0852e, 18'h09002,
		18'h09082, 18'h0952e, 18'h0dffe, 18'h0beef, 18'h00013, 18'h0ffff,
		18'h27ffc, 18'h2fffc, 18'h29c1d, 18'h29c3d, 18'h27ffe, 18'h2fffe,
		18'h30000, 18'h32000, 18'h38000, 18'h39c00, 18'h3a000, 18'h39c5d, 18'h39c7d, 18'h39c61,
		18'h32002, 18'h38002, 18'h3802e, 18'h3902e, 18'h3a002
	};

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	instr_t in_word;
	logic out_valid;
	logic out_ready;
	rvc_result_t out_result;

	rvc_result_t expected_q[$];
	logic [31:0] lfsr = 32'hf7c2;
	logic valid_model = 1'b0;
	int accepted = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	tb_clock_gen clock_gen (
		.clk_o(clk),
		.reset_o(reset)
	);

	rvc_expander #(.rv64_p(rv64)) UUT (
		.clk_i(clk),
		.reset_i(reset),
		.in_valid_i(in_valid),
		.in_ready_o(in_ready),
		.in_word_i(in_word),
		.out_valid_o(out_valid),
		.out_ready_i(out_ready),
		.out_result_o(out_result)
	);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	// stimulus with random gaps and output stalls
	initial begin
		int idx;
		instr_t rand_word;
		idx = 0;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b0;
		@(posedge clk);
		while (reset)
			@(posedge clk);
		forever begin
			if (!in_valid || in_ready) begin
				if (idx == n_words || rand_bits(2) == 0) begin
					in_valid <= 1'b0;
				end else begin
					in_valid <= 1'b1;
					if (idx < n_directed) begin
						in_word <= (rand_bits(16) << 16) | directed[idx][15:0];
					end else begin
						rand_word = rand_bits(32);
						// redraw the quadrant until the halfword is compressed
						while (rand_word[1:0] == 2'b11)
							rand_word[1:0] = rand_bits(2);
						in_word <= rand_word;
					end
					idx++;
				end
			end
			out_ready <= (rand_bits(2) != 0);
			@(posedge clk);
		end
	end

	// scoreboard and handshake checks
	always @(posedge clk) begin
		rvc_result_t want;
		if (!reset) begin
			check("in_ready_o", in_ready, !valid_model || out_ready);
			check("out_valid_o", out_valid, valid_model);
			if (out_valid && out_ready) begin
				if (expected_q.size() == 0) begin
					$display("output transfer with no accepted input left to match it");
					errors++;
				end else begin
					want = expected_q.pop_front();
					if (!want.illegal)
						check("out_result_o.instr", out_result.instr, want.instr);
					check("out_result_o.compressed", out_result.compressed, want.compressed);
					check("out_result_o.illegal", out_result.illegal, want.illegal);
				end
			end
			if (in_valid && in_ready) begin
				want = rvc_expand_ref(in_word, rv64);
				if (accepted < n_directed)
					check("directed illegal", want.illegal, directed[accepted][rv64 ? 16 : 17]);
				expected_q.push_back(want);
				accepted++;
			end
			valid_model = (in_valid && in_ready) || (valid_model && !out_ready);
			if (accepted == n_words && expected_q.size() == 0)
				end_run();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			if (in_valid)
				$display("timeout: word %0d still waiting for in_ready_o", accepted);
			else
				$display("timeout: %0d results never reached the output", expected_q.size());
			errors++;
			end_run();
		end
	end

endmodule

// ==== rvc_expander.f ====
+incdir+source
+incdir+tb
source/rvc_isa_pkg.sv
source/rvc_expand_pkg.sv
source/rvc_quadrant0.sv
source/rvc_quadrant1.sv
source/rvc_quadrant2.sv
source/rvc_format_pack.sv
source/rvc_expander.sv
tb/tb_clock_gen.sv
tb/tb_rvc_expander.sv

// ==== Bender.yml ====
package:
  name: rvc_expander

sources:
  - include_dirs:
      - source
    files:
      - source/rvc_isa_pkg.sv
      - source/rvc_expand_pkg.sv
      - source/rvc_quadrant0.sv
      - source/rvc_quadrant1.sv
      - source/rvc_quadrant2.sv
      - source/rvc_format_pack.sv
      - source/rvc_expander.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_rvc_expander.sv
